/* systolic_matmul.f */
+incdir+.
matmul_types_pkg.sv
matmul_ctrl_pkg.sv
matmul_ifs.sv
operand_feeder.sv
mac_pe.sv
pe_array.sv
result_unloader.sv
matmul_top.sv
matmul_props.sv
tb_matmul_checker.sv
tb_matmul.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the matmul testbench with Verilator, pass is decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_matmul -f systolic_matmul.f \
  > sim.log 2>&1 \
  && ./obj_dir/Vtb_matmul >> sim.log 2>&1
cat sim.log
grep -q '^>>> PASS$' sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* tb_matmul.sv */
`timescale 1ns/1ps
`include "matmul_defs.svh"

module tb_matmul;

  localparam int CLK_PERIOD = 40;
  localparam int MEM_WORDS  = 1 << `MM_AWIDTH;
  localparam int RUN_CYCLES = 32;
  localparam int TOTAL_RUNS = 20;
  localparam int WATCHDOG_NS = (TOTAL_RUNS * RUN_CYCLES + 100) * CLK_PERIOD;

  logic clk = 1'b0;
  logic reset;
  logic i_start;
  matmul_types_pkg::addr_t      i_addr_a, i_addr_b, i_addr_c;
  matmul_types_pkg::stride_t    i_stride_a, i_stride_b, i_stride_c;
  matmul_types_pkg::lane_word_t i_a_data, i_b_data;
  matmul_types_pkg::mask_t      i_mask_a_rows, i_mask_k, i_mask_b_cols;
  matmul_types_pkg::addr_t      o_a_addr, o_b_addr, o_c_addr;
  matmul_types_pkg::lane_word_t o_c_data;
  logic o_c_valid, o_done;
  matmul_types_pkg::lane_word_t mem_a [MEM_WORDS];
  matmul_types_pkg::lane_word_t mem_b [MEM_WORDS];
  int chk_errs, chk_dones;
  int tb_errs = 0;
  int tests = 0;
  int failed_tests = 0;
  logic [31:0] lfsr = 32'h55d5b8a7;

  always #(CLK_PERIOD / 2) clk = ~clk;

  matmul_top dut0 (.*);

  tb_matmul_checker chk0 (
    .clk (clk), .reset (reset), .i_start (i_start),
    .i_addr_a (i_addr_a), .i_addr_b (i_addr_b), .i_addr_c (i_addr_c),
    .i_stride_a (i_stride_a), .i_stride_b (i_stride_b), .i_stride_c (i_stride_c),
    .i_mask_a_rows (i_mask_a_rows), .i_mask_k (i_mask_k), .i_mask_b_cols (i_mask_b_cols),
    .mem_a (mem_a), .mem_b (mem_b),
    .o_a_addr (o_a_addr), .o_b_addr (o_b_addr), .o_c_addr (o_c_addr),
    .o_c_data (o_c_data), .o_c_valid (o_c_valid), .o_done (o_done),
    .o_err_cnt (chk_errs), .o_done_cnt (chk_dones)
  );

  // Operand memories with one cycle of read latency
  always @(posedge clk) begin
    i_a_data <= mem_a[o_a_addr];
    i_b_data <= mem_b[o_b_addr];
  end

  ////////////////////////////////////////////////////////////////////////////
  // Fibonacci LFSR with taps 32 22 2 1 as the random source
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic int total_errors();
    return chk_errs + tb_errs + dut0.props0.assert_fails;
  endfunction

  // Draws new bases, strides, masks and matrices and drives them on the current edge
  task automatic load_operands(input bit rand_masks);
    logic [31:0] v;
    logic [31:0] t;
    matmul_types_pkg::addr_t   ba, bb;
    matmul_types_pkg::stride_t sa, sb;
    draw_bits(`MM_AWIDTH, v);
    ba = v[`MM_AWIDTH-1:0];
    draw_bits(`MM_AWIDTH, v);
    bb = v[`MM_AWIDTH-1:0];
    draw_bits(`MM_STRIDE_WIDTH, v);
    sa = v[`MM_STRIDE_WIDTH-1:0];
    draw_bits(`MM_STRIDE_WIDTH, v);
    sb = v[`MM_STRIDE_WIDTH-1:0];
    i_addr_a   <= ba;
    i_addr_b   <= bb;
    i_stride_a <= sa;
    i_stride_b <= sb;
    draw_bits(`MM_AWIDTH, v);
    i_addr_c <= v[`MM_AWIDTH-1:0];
    draw_bits(`MM_STRIDE_WIDTH, v);
    i_stride_c <= v[`MM_STRIDE_WIDTH-1:0];
    for (int k = 0; k < `MM_SIZE; k++) begin
      draw_bits(32, v);
      t = 32'(ba) + 32'(k) * 32'(sa);
      mem_a[t[`MM_AWIDTH-1:0]] <= v;
      draw_bits(32, v);
      t = 32'(bb) + 32'(k) * 32'(sb);
      mem_b[t[`MM_AWIDTH-1:0]] <= v;
    end
    if (rand_masks) begin
      draw_bits(`MM_SIZE, v);
      i_mask_a_rows <= v[`MM_SIZE-1:0];
      draw_bits(`MM_SIZE, v);
      i_mask_k <= v[`MM_SIZE-1:0];
      draw_bits(`MM_SIZE, v);
      i_mask_b_cols <= v[`MM_SIZE-1:0];
    end else begin
      i_mask_a_rows <= '1;
      i_mask_k      <= '1;
      i_mask_b_cols <= '1;
    end
  endtask

  // Runs one multiply and aborts it after abort_at edges when abort_at is positive
  // Returns on the edge that saw done while i_start is still high
  task automatic run_matmul(input bit rand_masks, input int abort_at);
    int dones_before;
    bit seen;
    load_operands(rand_masks);
    @(posedge clk);
    i_start <= 1'b1;
    if (abort_at > 0) begin
      repeat (abort_at) @(posedge clk);
      i_start <= 1'b0;
      dones_before = chk_dones;
      repeat (RUN_CYCLES) @(posedge clk);
      if (chk_dones != dones_before) begin
        $display("Aborted run still produced a done pulse");
        tb_errs++;
      end
    end else begin
      seen = 1'b0;
      for (int i = 0; i < RUN_CYCLES && !seen; i++) begin
        @(posedge clk);
        seen = o_done;
      end
      if (!seen) begin
        $display("No done pulse within %0d cycles of the start", RUN_CYCLES);
        tb_errs++;
      end
    end
  endtask

  task automatic idle_cycles(input int n);
    i_start <= 1'b0;
    repeat (n) @(posedge clk);
  endtask

  task automatic close_test(input string name, input int errs_before);
    // Two edges let the checker counters catch up
    repeat (2) @(posedge clk);
    tests++;
    if (total_errors() != errs_before) begin
      failed_tests++;
      $display("test %0d %s: FAILED", tests, name);
    end else begin
      $display("test %0d %s: ok", tests, name);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int e;
    logic [31:0] v;
    reset = 1'b1;
    i_start = 1'b0;
    i_addr_a = '0;
    i_addr_b = '0;
    i_addr_c = '0;
    i_stride_a = '0;
    i_stride_b = '0;
    i_stride_c = '0;
    i_a_data = '0;
    i_b_data = '0;
    i_mask_a_rows = '1;
    i_mask_k = '1;
    i_mask_b_cols = '1;
    // Background contents differ for every address
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_a[i] <= 32'(i) * 32'h9e3779b1;
      mem_b[i] <= ~(32'(i) * 32'h85ebca6b);
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    e = total_errors();
    idle_cycles(6);
    close_test("idle after reset", e);

    for (int n = 0; n < 4; n++) begin
      e = total_errors();
      run_matmul(1'b0, 0);
      idle_cycles(3);
      close_test("full masks", e);
    end
    for (int n = 0; n < 4; n++) begin
      e = total_errors();
      run_matmul(1'b1, 0);
      idle_cycles(3);
      close_test("random masks", e);
    end
    for (int n = 0; n < 3; n++) begin
      e = total_errors();
      draw_bits(4, v);
      run_matmul(1'b1, 1 + int'(v[3:0]) % 12);
      idle_cycles(2);
      run_matmul(1'b1, 0);
      idle_cycles(3);
      close_test("abort then full run", e);
    end
    e = total_errors();
    for (int n = 0; n < 3; n++) begin
      // The next setup shares the edge that drops i_start so the runs are one low cycle apart
      run_matmul(1'b1, 0);
      i_start <= 1'b0;
    end
    idle_cycles(3);
    close_test("back to back runs", e);

    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, total_errors());
    if (failed_tests == 0 && total_errors() == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog sized from the number of runs and their length
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout, the test sequence did not finish in %0d ns", WATCHDOG_NS);
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* tb_matmul_checker.sv */
`timescale 1ns/1ps
`include "matmul_defs.svh"

// Watches the DUT ports, rebuilds each run's product from the operand
// memories and compares fetch addresses, result words and done
module tb_matmul_checker (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         i_start,
  input  matmul_types_pkg::addr_t      i_addr_a,
  input  matmul_types_pkg::addr_t      i_addr_b,
  input  matmul_types_pkg::addr_t      i_addr_c,
  input  matmul_types_pkg::stride_t    i_stride_a,
  input  matmul_types_pkg::stride_t    i_stride_b,
  input  matmul_types_pkg::stride_t    i_stride_c,
  input  matmul_types_pkg::mask_t      i_mask_a_rows,
  input  matmul_types_pkg::mask_t      i_mask_k,
  input  matmul_types_pkg::mask_t      i_mask_b_cols,
  input  matmul_types_pkg::lane_word_t mem_a [1 << `MM_AWIDTH],
  input  matmul_types_pkg::lane_word_t mem_b [1 << `MM_AWIDTH],
  input  matmul_types_pkg::addr_t      o_a_addr,
  input  matmul_types_pkg::addr_t      o_b_addr,
  input  matmul_types_pkg::addr_t      o_c_addr,
  input  matmul_types_pkg::lane_word_t o_c_data,
  input  logic                         o_c_valid,
  input  logic                         o_done,
  output int                           o_err_cnt,
  output int                           o_done_cnt
);

  localparam int SAT_HI = (1 << (`MM_DWIDTH - 1)) - 1;
  localparam int SAT_LO = -SAT_HI - 1;

  int   errs = 0;
  int   dones = 0;
  int   cyc = -1;
  int   word_cnt = 0;
  logic prev_start = 1'b0;
  logic prev_valid = 1'b0;
  matmul_types_pkg::lane_word_t exp_words [`MM_SIZE];

  // Address k of an operand is base plus k strides and wraps in the address width
  function automatic matmul_types_pkg::addr_t stride_addr(input matmul_types_pkg::addr_t base,
                                                          input int offset);
    logic [31:0] t;
    t = 32'(base) + 32'(offset);
    return t[`MM_AWIDTH-1:0];
  endfunction

  // Signed product clamped to the element range
  function automatic int clamp_product(input int a, input int b);
    int p;
    p = a * b;
    if (p > SAT_HI) p = SAT_HI;
    if (p < SAT_LO) p = SAT_LO;
    return p;
  endfunction

  task automatic report_mismatch(input string name, input int idx, input logic [31:0] exp_v,
                                 input logic [31:0] got_v);
    $display("** Error: %s [%0d] expected %h got %h", name, idx, exp_v, got_v);
    errs++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // A word k holds column k of A and B word k holds row k of B
  // Column c of C goes out as word c
  task automatic build_expected();
    matmul_types_pkg::lane_word_t wa;
    matmul_types_pkg::lane_word_t wb;
    matmul_types_pkg::elem_t      ea;
    matmul_types_pkg::elem_t      eb;
    int sum;
    for (int c = 0; c < `MM_SIZE; c++) begin
      for (int r = 0; r < `MM_SIZE; r++) begin
        sum = 0;
        for (int k = 0; k < `MM_SIZE; k++) begin
          wa = mem_a[stride_addr(i_addr_a, k * int'(i_stride_a))];
          wb = mem_b[stride_addr(i_addr_b, k * int'(i_stride_b))];
          ea = wa[r*`MM_DWIDTH +: `MM_DWIDTH];
          eb = wb[c*`MM_DWIDTH +: `MM_DWIDTH];
          if (i_mask_k[k] && i_mask_a_rows[r] && i_mask_b_cols[c]) begin
            sum += clamp_product(int'(ea), int'(eb));
          end
        end
        // The accumulator keeps only the low element bits
        exp_words[c][r*`MM_DWIDTH +: `MM_DWIDTH] = sum[`MM_DWIDTH-1:0];
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Port monitor that samples at the rising edge
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (reset) begin
      cyc        = -1;
      word_cnt   = 0;
      prev_start = 1'b0;
      prev_valid = 1'b0;
    end else begin
      // Outputs must be quiet after an edge that saw i_start low
      if (!prev_start) begin
        if (o_c_valid) report_mismatch("o_c_valid", 0, 32'd0, 32'(o_c_valid));
        if (o_done) report_mismatch("o_done", 0, 32'd0, 32'(o_done));
        if (o_c_data != '0) report_mismatch("o_c_data", 0, 32'd0, 32'(o_c_data));
      end
      if (o_c_valid && prev_start) begin
        if (cyc < 1 || word_cnt >= `MM_SIZE) begin
          $display("Result word seen outside the unload window of a run");
          errs++;
        end else begin
          // The four words of a run come in consecutive cycles
          if (word_cnt > 0 && !prev_valid) begin
            $display("Result word %0d did not directly follow word %0d", word_cnt,
                     word_cnt - 1);
            errs++;
          end
          if (o_c_data != exp_words[word_cnt]) begin
            report_mismatch("o_c_data", word_cnt, 32'(exp_words[word_cnt]), 32'(o_c_data));
          end
          if (o_c_addr != stride_addr(i_addr_c, -(word_cnt * int'(i_stride_c)))) begin
            report_mismatch("o_c_addr", word_cnt,
                            32'(stride_addr(i_addr_c, -(word_cnt * int'(i_stride_c)))),
                            32'(o_c_addr));
          end
        end
        word_cnt++;
      end
      if (o_done && prev_start) begin
        if (word_cnt != `MM_SIZE) begin
          $display("Done pulse came after %0d result words instead of %0d", word_cnt, `MM_SIZE);
          errs++;
        end else if (!prev_valid) begin
          $display("Done pulse did not come directly after the last result word");
          errs++;
        end
        dones++;
      end
      // Run cycle 0 is the first edge with i_start high
      if (!i_start) begin
        cyc = -1;
      end else if (cyc < 0) begin
        cyc      = 0;
        word_cnt = 0;
      end else begin
        cyc++;
      end
      if (cyc == 1) build_expected();
      if (cyc >= 1 && cyc <= `MM_SIZE) begin
        if (o_a_addr != stride_addr(i_addr_a, (cyc - 1) * int'(i_stride_a))) begin
          report_mismatch("o_a_addr", cyc - 1,
                          32'(stride_addr(i_addr_a, (cyc - 1) * int'(i_stride_a))),
                          32'(o_a_addr));
        end
        if (o_b_addr != stride_addr(i_addr_b, (cyc - 1) * int'(i_stride_b))) begin
          report_mismatch("o_b_addr", cyc - 1,
                          32'(stride_addr(i_addr_b, (cyc - 1) * int'(i_stride_b))),
                          32'(o_b_addr));
        end
      end
      prev_start = i_start;
      prev_valid = o_c_valid;
    end
    o_err_cnt  <= errs;
    o_done_cnt <= dones;
  end

endmodule

/* matmul_props.sv */
`timescale 1ns/1ps
`include "matmul_defs.svh"

// Control protocol rules of the matmul top level, bound into every instance
module matmul_props (
  input logic clk,
  input logic reset,
  input logic i_start,
  input logic o_c_valid,
  input logic o_done
);

  // Failed assertions, read by the testbench for its final verdict
  int assert_fails = 0;

  // Set by the done pulse of a run and cleared once i_start falls
  logic done_seen;

  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      done_seen <= 1'b0;
    end else if (o_done) begin
      done_seen <= 1'b1;
    end
  end

  // The last result word and the done pulse never share a cycle
  valid_not_with_done: assert property (
    @(posedge clk) disable iff (reset) !(o_c_valid && o_done)
  ) else begin
    assert_fails++;
    $error("o_c_valid and o_done are high in the same cycle");
  end

  // A run has at most one done pulse
  single_done_per_run: assert property (
    @(posedge clk) disable iff (reset) done_seen |-> !o_done
  ) else begin
    assert_fails++;
    $error("o_done pulsed a second time in one run");
  end

  // Dropping i_start silences the outputs at the next edge
  idle_after_start_low: assert property (
    @(posedge clk) disable iff (reset) !i_start |=> (!o_c_valid && !o_done)
  ) else begin
    assert_fails++;
    $error("o_c_valid or o_done high after an edge with i_start low");
  end

endmodule

bind matmul_top matmul_props props0 (
  .clk       (clk),
  .reset     (reset),
  .i_start   (i_start),
  .o_c_valid (o_c_valid),
  .o_done    (o_done)
);

/* matmul_top.sv */
`timescale 1ns/1ps
`include "matmul_defs.svh"

// Single 4x4 systolic matrix multiply with memory fetch and column unload
module matmul_top (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         i_start,
  input  matmul_types_pkg::addr_t      i_addr_a,
  input  matmul_types_pkg::addr_t      i_addr_b,
  input  matmul_types_pkg::addr_t      i_addr_c,
  input  matmul_types_pkg::stride_t    i_stride_a,
  input  matmul_types_pkg::stride_t    i_stride_b,
  input  matmul_types_pkg::stride_t    i_stride_c,
  input  matmul_types_pkg::lane_word_t i_a_data,
  input  matmul_types_pkg::lane_word_t i_b_data,
  input  matmul_types_pkg::mask_t      i_mask_a_rows,
  input  matmul_types_pkg::mask_t      i_mask_k,
  input  matmul_types_pkg::mask_t      i_mask_b_cols,
  output matmul_types_pkg::addr_t      o_a_addr,
  output matmul_types_pkg::addr_t      o_b_addr,
  output matmul_types_pkg::addr_t      o_c_addr,
  output matmul_types_pkg::lane_word_t o_c_data,
  output logic                         o_c_valid,
  output logic                         o_done
);

  feed_if feed ();
  grid_if grid ();

  // Run control, operand fetch and skew
  operand_feeder u_feeder (
    .clk           (clk),
    .reset         (reset),
    .i_start       (i_start),
    .i_addr_a      (i_addr_a),
    .i_addr_b      (i_addr_b),
    .i_stride_a    (i_stride_a),
    .i_stride_b    (i_stride_b),
    .i_a_data      (i_a_data),
    .i_b_data      (i_b_data),
    .i_mask_a_rows (i_mask_a_rows),
    .i_mask_k      (i_mask_k),
    .i_mask_b_cols (i_mask_b_cols),
    .o_a_addr      (o_a_addr),
    .o_b_addr      (o_b_addr),
    .feed          (feed)
  );

  pe_array u_pe_array (
    .clk   (clk),
    .reset (reset),
    .feed  (feed),
    .grid  (grid)
  );

  // Column unload and done
  result_unloader u_unloader (
    .clk        (clk),
    .reset      (reset),
    .i_addr_c   (i_addr_c),
    .i_stride_c (i_stride_c),
    .feed       (feed),
    .grid       (grid),
    .o_c_addr   (o_c_addr),
    .o_c_data   (o_c_data),
    .o_c_valid  (o_c_valid),
    .o_done     (o_done)
  );

endmodule

/* result_unloader.sv */
`timescale 1ns/1ps
`include "matmul_defs.svh"

// Waits for the grid to settle, then streams C out one column per cycle on
// descending addresses and pulses done
module result_unloader (
  input  logic                         clk,
  input  logic                         reset,
  input  matmul_types_pkg::addr_t      i_addr_c,
  input  matmul_types_pkg::stride_t    i_stride_c,
  feed_if.sink                         feed,
  grid_if.sink                         grid,
  output matmul_types_pkg::addr_t      o_c_addr,
  output matmul_types_pkg::lane_word_t o_c_data,
  output logic                         o_c_valid,
  output logic                         o_done
);

  localparam int IDX_W = $clog2(`MM_SIZE);

  localparam matmul_ctrl_pkg::step_cnt_t DRAIN_LAST = `MM_DRAIN_CYCLES;
  localparam matmul_ctrl_pkg::step_cnt_t WORD_COUNT = `MM_SIZE;

  matmul_ctrl_pkg::unload_state_t state;
  matmul_ctrl_pkg::step_cnt_t     step;
  logic [IDX_W-1:0]               col_sel;
  matmul_types_pkg::lane_word_t   col_word;

  ////////////////////////////////////////////////////////////////////////////
  // Column select
  ////////////////////////////////////////////////////////////////////////////

  // Column 0 leaves at the end of the drain, the others during unload
  assign col_sel = (state == matmul_ctrl_pkg::UL_UNLOAD) ? step[IDX_W-1:0] : '0;

  // Row r of the selected column goes to lane r of the output word
  always_comb begin
    for (int r = 0; r < `MM_SIZE; r++) begin
      col_word[r*`MM_DWIDTH +: `MM_DWIDTH] = grid.c_grid[r][col_sel];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Unload FSM
  ////////////////////////////////////////////////////////////////////////////

  // In the drain state, step equals k at the k-th edge after fetch_last
  always_ff @(posedge clk) begin
    if (reset || feed.clear) begin
      state     <= matmul_ctrl_pkg::UL_IDLE;
      step      <= '0;
      o_c_valid <= 1'b0;
      o_done    <= 1'b0;
      o_c_data  <= '0;
    end else begin
      o_done <= 1'b0;
      case (state)
        matmul_ctrl_pkg::UL_IDLE: begin
          if (feed.fetch_last) begin
            state <= matmul_ctrl_pkg::UL_DRAIN;
            step  <= 1;
          end
        end
        matmul_ctrl_pkg::UL_DRAIN: begin
          if (step == DRAIN_LAST) begin
            // Last accumulator of column 0 has landed
            o_c_data  <= col_word;
            o_c_valid <= 1'b1;
            step      <= 1;
            state     <= matmul_ctrl_pkg::UL_UNLOAD;
          end else begin
            step <= step + 1'b1;
          end
        end
        matmul_ctrl_pkg::UL_UNLOAD: begin
          if (step == WORD_COUNT) begin
            o_c_valid <= 1'b0;
            o_c_data  <= '0;
            o_done    <= 1'b1;
            state     <= matmul_ctrl_pkg::UL_FINISHED;
          end else begin
            o_c_data <= col_word;
            step     <= step + 1'b1;
          end
        end
        default: begin
          // Stay quiet until the feeder raises clear
          state <= matmul_ctrl_pkg::UL_FINISHED;
        end
      endcase
    end
  end

  // Word j goes to the base minus j strides
  always_ff @(posedge clk) begin
    if (state == matmul_ctrl_pkg::UL_UNLOAD) begin
      o_c_addr <= o_c_addr - matmul_types_pkg::addr_t'(i_stride_c);
    end else begin
      o_c_addr <= i_addr_c;
    end
  end

endmodule

/* pe_array.sv */
`timescale 1ns/1ps
`include "matmul_defs.svh"

// Square grid of MACs, A moves right along a row and B moves down a column
module pe_array (
  input  logic  clk,
  input  logic  reset,
  feed_if.sink  feed,
  grid_if.source grid
);

  // Forwarded operands, a_fwd[r][c] leaves PE (r,c) to the right and
  // b_fwd[r][c] leaves it downward
  matmul_types_pkg::elem_t a_fwd [`MM_SIZE][`MM_SIZE];
  matmul_types_pkg::elem_t b_fwd [`MM_SIZE][`MM_SIZE];

  for (genvar r = 0; r < `MM_SIZE; r++) begin : g_row
    for (genvar c = 0; c < `MM_SIZE; c++) begin : g_col
      matmul_types_pkg::elem_t a_in;
      matmul_types_pkg::elem_t b_in;

      // Left column takes the A lane, others take the neighbour on the left
      if (c == 0) begin : g_a_edge
        assign a_in = feed.a_lane[r];
      end else begin : g_a_inner
        assign a_in = a_fwd[r][c-1];
      end

      // Top row takes the B lane, others take the neighbour above
      if (r == 0) begin : g_b_edge
        assign b_in = feed.b_lane[c];
      end else begin : g_b_inner
        assign b_in = b_fwd[r-1][c];
      end

      mac_pe u_pe (
        .clk     (clk),
        .reset   (reset),
        .i_clear (feed.clear),
        .i_a     (a_in),
        .i_b     (b_in),
        .o_a     (a_fwd[r][c]),
        .o_b     (b_fwd[r][c]),
        .o_acc   (grid.c_grid[r][c])
      );
    end
  end

endmodule

/* mac_pe.sv */
`timescale 1ns/1ps
`include "matmul_defs.svh"

// One systolic processing element with a saturating signed multiply and a
// wrapping accumulator
module mac_pe (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    i_clear,
  input  matmul_types_pkg::elem_t i_a,
  input  matmul_types_pkg::elem_t i_b,
  output matmul_types_pkg::elem_t o_a,
  output matmul_types_pkg::elem_t o_b,
  output matmul_types_pkg::elem_t o_acc
);

  // Element range as product values, 127 and -128 for 8 bit elements
  localparam matmul_types_pkg::prod_t SAT_HI = (1 << (`MM_DWIDTH - 1)) - 1;
  localparam matmul_types_pkg::prod_t SAT_LO = -SAT_HI - 1;

  matmul_types_pkg::elem_t a_mul;
  matmul_types_pkg::elem_t b_mul;
  matmul_types_pkg::prod_t prod;
  matmul_types_pkg::elem_t prod_sat;

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline of forward, multiply and accumulate registers
  ////////////////////////////////////////////////////////////////////////////

  // Operands go right and down one cycle later while a second copy feeds
  // the multiplier, so the accumulator trails the inputs by three cycles
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      o_a   <= '0;
      o_b   <= '0;
      a_mul <= '0;
      b_mul <= '0;
      prod  <= '0;
      o_acc <= '0;
    end else begin
      o_a   <= i_a;
      o_b   <= i_b;
      a_mul <= i_a;
      b_mul <= i_b;
      prod  <= a_mul * b_mul;
      // Sum wraps modulo 256
      o_acc <= o_acc + prod_sat;
    end
  end

  // Clamp the product to the element range before it is added
  always_comb begin
    if (prod > SAT_HI) begin
      prod_sat = matmul_types_pkg::elem_t'(SAT_HI);
    end else if (prod < SAT_LO) begin
      prod_sat = matmul_types_pkg::elem_t'(SAT_LO);
    end else begin
      prod_sat = matmul_types_pkg::elem_t'(prod);
    end
  end

endmodule

/* operand_feeder.sv */
`timescale 1ns/1ps
`include "matmul_defs.svh"

// Fetches the four A column words and four B row words of a run,
// masks them and skews them into the systolic grid
module operand_feeder (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        i_start,
  input  matmul_types_pkg::addr_t     i_addr_a,
  input  matmul_types_pkg::addr_t     i_addr_b,
  input  matmul_types_pkg::stride_t   i_stride_a,
  input  matmul_types_pkg::stride_t   i_stride_b,
  input  matmul_types_pkg::lane_word_t i_a_data,
  input  matmul_types_pkg::lane_word_t i_b_data,
  input  matmul_types_pkg::mask_t     i_mask_a_rows,
  input  matmul_types_pkg::mask_t     i_mask_k,
  input  matmul_types_pkg::mask_t     i_mask_b_cols,
  output matmul_types_pkg::addr_t     o_a_addr,
  output matmul_types_pkg::addr_t     o_b_addr,
  feed_if.source                      feed
);

  localparam int IDX_W = $clog2(`MM_SIZE);

  // The word of fetch i is on the data inputs while run_cnt equals FIRST_WORD + i
  localparam matmul_ctrl_pkg::step_cnt_t LAST_ADDR  = `MM_SIZE - 1;
  localparam matmul_ctrl_pkg::step_cnt_t FIRST_WORD = 1 + `MM_MEM_LATENCY;
  localparam matmul_ctrl_pkg::step_cnt_t LAST_WORD  = `MM_MEM_LATENCY + `MM_SIZE;

  matmul_ctrl_pkg::feed_state_t state;
  matmul_ctrl_pkg::step_cnt_t   run_cnt;
  logic                         run_clear;
  logic                         word_live;
  logic [IDX_W-1:0]             word_idx;
  matmul_types_pkg::elem_t      a_gated [`MM_SIZE];
  matmul_types_pkg::elem_t      b_gated [`MM_SIZE];

  ////////////////////////////////////////////////////////////////////////////
  // Run FSM
  ////////////////////////////////////////////////////////////////////////////

  // run_cnt equals n in the cycle that ends with run edge n
  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      state   <= matmul_ctrl_pkg::FEED_IDLE;
      run_cnt <= '0;
    end else begin
      case (state)
        matmul_ctrl_pkg::FEED_IDLE: begin
          state   <= matmul_ctrl_pkg::FEED_FETCH;
          run_cnt <= 1;
        end
        matmul_ctrl_pkg::FEED_FETCH: begin
          run_cnt <= run_cnt + 1'b1;
          if (run_cnt == LAST_ADDR) begin
            state <= matmul_ctrl_pkg::FEED_HOLD;
          end
        end
        default: begin
          // Saturate so that the word window and fetch_last never repeat
          if (run_cnt != '1) begin
            run_cnt <= run_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // Base is loaded while idle, then one stride is added per fetch
  always_ff @(posedge clk) begin
    if (state == matmul_ctrl_pkg::FEED_IDLE) begin
      o_a_addr <= i_addr_a;
      o_b_addr <= i_addr_b;
    end else if (state == matmul_ctrl_pkg::FEED_FETCH) begin
      o_a_addr <= o_a_addr + matmul_types_pkg::addr_t'(i_stride_a);
      o_b_addr <= o_b_addr + matmul_types_pkg::addr_t'(i_stride_b);
    end
  end

  assign run_clear       = !i_start || (state == matmul_ctrl_pkg::FEED_IDLE);
  assign feed.clear      = run_clear;
  assign feed.fetch_last = !run_clear && (run_cnt == LAST_WORD);

  ////////////////////////////////////////////////////////////////////////////
  // Validity gating
  ////////////////////////////////////////////////////////////////////////////

  // Inner index of the word now on the data inputs
  assign word_idx  = IDX_W'(run_cnt - FIRST_WORD);
  assign word_live = (run_cnt >= FIRST_WORD) && (run_cnt <= LAST_WORD) && i_mask_k[word_idx];

  always_comb begin
    for (int i = 0; i < `MM_SIZE; i++) begin
      a_gated[i] = '0;
      b_gated[i] = '0;
      if (word_live && i_mask_a_rows[i]) begin
        a_gated[i] = matmul_types_pkg::elem_t'(i_a_data[i*`MM_DWIDTH +: `MM_DWIDTH]);
      end
      if (word_live && i_mask_b_cols[i]) begin
        b_gated[i] = matmul_types_pkg::elem_t'(i_b_data[i*`MM_DWIDTH +: `MM_DWIDTH]);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Triangular skew, lane r runs through r registers
  ////////////////////////////////////////////////////////////////////////////

  for (genvar r = 0; r < `MM_SIZE; r++) begin : g_lane
    if (r == 0) begin : g_direct
      assign feed.a_lane[r] = a_gated[r];
      assign feed.b_lane[r] = b_gated[r];
    end else begin : g_skew
      matmul_types_pkg::elem_t a_pipe [r];
      matmul_types_pkg::elem_t b_pipe [r];

      always_ff @(posedge clk) begin
        if (reset || run_clear) begin
          a_pipe <= '{default: '0};
          b_pipe <= '{default: '0};
        end else begin
          a_pipe[0] <= a_gated[r];
          b_pipe[0] <= b_gated[r];
          for (int s = 1; s < r; s++) begin
            a_pipe[s] <= a_pipe[s-1];
            b_pipe[s] <= b_pipe[s-1];
          end
        end
      end

      assign feed.a_lane[r] = a_pipe[r-1];
      assign feed.b_lane[r] = b_pipe[r-1];
    end
  end

endmodule

/* matmul_ifs.sv */
`timescale 1ns/1ps
`include "matmul_defs.svh"

////////////////////////////////////////////////////////////////////////////
// Operand feed from the feeder into the grid and the unloader
////////////////////////////////////////////////////////////////////////////

interface feed_if;

  // Skewed operand lanes, lane r of A enters row r and lane c of B column c
  matmul_types_pkg::elem_t a_lane [`MM_SIZE];
  matmul_types_pkg::elem_t b_lane [`MM_SIZE];

  // High whenever no run is active, flushes the grid and the unloader
  logic clear;

  // Single cycle strobe while the last A and B words sit on lane 0
  logic fetch_last;

  modport source (output a_lane, output b_lane, output clear, output fetch_last);

  modport sink (input a_lane, input b_lane, input clear, input fetch_last);

endinterface

////////////////////////////////////////////////////////////////////////////
// Accumulator grid from the PE array into the unloader
////////////////////////////////////////////////////////////////////////////

interface grid_if;

  // Accumulator of the PE in row r and column c sits at c_grid[r][c]
  matmul_types_pkg::elem_t c_grid [`MM_SIZE][`MM_SIZE];

  modport source (output c_grid);

  modport sink (input c_grid);

endinterface

/* matmul_ctrl_pkg.sv */
`include "matmul_defs.svh"

// Control types for the two run FSMs
package matmul_ctrl_pkg;

  // Feeder FSM, the hold state waits for i_start to fall after the fetches
  typedef enum logic [1:0] {
    FEED_IDLE,
    FEED_FETCH,
    FEED_HOLD
  } feed_state_t;

  // Unloader FSM
  typedef enum logic [1:0] {
    UL_IDLE,
    UL_DRAIN,
    UL_UNLOAD,
    UL_FINISHED
  } unload_state_t;

  // Small cycle counter used by both FSMs
  typedef logic [`MM_STEP_WIDTH-1:0] step_cnt_t;

endpackage

/* matmul_types_pkg.sv */
`include "matmul_defs.svh"

// Data and address types shared by the feeder, the grid and the unloader
package matmul_types_pkg;

  // One matrix element, two's complement
  typedef logic signed [`MM_DWIDTH-1:0] elem_t;

  // Full product of two elements before saturation
  typedef logic signed [2*`MM_DWIDTH-1:0] prod_t;

  // One memory word holding MM_SIZE elements
  // Element 0 sits in the low bits
  typedef logic [`MM_WORD_WIDTH-1:0] lane_word_t;

  // Memory address for A, B and C
  typedef logic [`MM_AWIDTH-1:0] addr_t;

  // Distance between consecutive words of one operand
  typedef logic [`MM_STRIDE_WIDTH-1:0] stride_t;

  // Validity mask, bit i belongs to index i
  typedef logic [`MM_MASK_WIDTH-1:0] mask_t;

endpackage

/* matmul_defs.svh */
`ifndef MATMUL_DEFS_SVH
`define MATMUL_DEFS_SVH

// Element width of A, B and C in bits
`define MM_DWIDTH 8

// Matrix dimension, also the number of elements in one memory word
`define MM_SIZE 4

// Memory address and address stride widths
`define MM_AWIDTH 11
`define MM_STRIDE_WIDTH 8

// One mask bit per row, column or inner index
`define MM_MASK_WIDTH `MM_SIZE

// Width of a packed memory word
`define MM_WORD_WIDTH (`MM_SIZE * `MM_DWIDTH)

// Read latency of the operand memories in cycles
`define MM_MEM_LATENCY 1

// Operand register, product register and accumulator
`define MM_MAC_STAGES 3

// Lane r of the operand skew is r cycles late, so the deepest lane lags by this
`define MM_SKEW_DEPTH (`MM_SIZE - 1)

// Edges from the one that samples fetch_last to the one that registers word 0
`define MM_DRAIN_CYCLES (`MM_SKEW_DEPTH + `MM_MAC_STAGES)

// Width of the run and unload step counters
`define MM_STEP_WIDTH 4

`endif
